/* ooo_pkg.sv */
package ooo_pkg;

    localparam int xlen = 32;
    localparam int reg_idx_w = 5;  // x0 reads as zero.

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_sltu,
        op_sll,
        op_srl,
        op_sra,
        op_lui,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_jal
    } opcode_e;

    // conditional branches only, jal is handled apart.
    function automatic logic is_branch(input opcode_e op);
        return op inside {op_beq, op_bne, op_blt, op_bge};
    endfunction

endpackage

/* reg_status.sv */
`timescale 1ns/10ps

module reg_status import ooo_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [reg_idx_w-1:0]         rs1,
    input  logic [reg_idx_w-1:0]         rs2,
    output logic [xlen-1:0]              rs1_value,
    output logic [xlen-1:0]              rs2_value,
    output logic                         rs1_pending,
    output logic                         rs2_pending,
    output logic [$clog2(rob_depth)-1:0] rs1_tag,
    output logic [$clog2(rob_depth)-1:0] rs2_tag,
    input  logic                         alloc_valid,
    input  logic [reg_idx_w-1:0]         alloc_rd,
    input  logic [$clog2(rob_depth)-1:0] alloc_tag,
    input  logic                         commit_valid,
    input  logic [reg_idx_w-1:0]         commit_rd,
    input  logic [xlen-1:0]              commit_value,
    input  logic [$clog2(rob_depth)-1:0] commit_tag,
    input  logic                         flush
);
    localparam int tag_w = $clog2(rob_depth);

    logic [xlen-1:0]  regs [1:31];
    logic [tag_w-1:0] tags [1:31];
    logic [31:1]      pend;

    // the producer commits this cycle, so its value is already final.
    function automatic logic commit_hit(input logic [reg_idx_w-1:0] idx);
        return commit_valid && commit_rd == idx && tags[idx] == commit_tag;
    endfunction

    assign rs1_pending = rs1 != '0 && pend[rs1] && !commit_hit(rs1);
    assign rs2_pending = rs2 != '0 && pend[rs2] && !commit_hit(rs2);
    assign rs1_tag = rs1 == '0 ? '0 : tags[rs1];
    assign rs2_tag = rs2 == '0 ? '0 : tags[rs2];
    assign rs1_value = rs1 == '0 ? '0 : (pend[rs1] && commit_hit(rs1)) ? commit_value : regs[rs1];
    assign rs2_value = rs2 == '0 ? '0 : (pend[rs2] && commit_hit(rs2)) ? commit_value : regs[rs2];

    always_ff @(posedge clk) begin
        if (!rst) begin
            pend <= '0;
        end else if (flush) begin
            pend <= '0;
        end else begin
            if (commit_valid && commit_rd != '0 && tags[commit_rd] == commit_tag) begin
                pend[commit_rd] <= 1'b0;
            end
            if (alloc_valid && alloc_rd != '0) begin
                pend[alloc_rd] <= 1'b1;  // newer tag wins.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (commit_valid && commit_rd != '0) begin
            regs[commit_rd] <= commit_value;
        end
        if (alloc_valid && alloc_rd != '0) begin
            tags[alloc_rd] <= alloc_tag;
        end
    end

endmodule

/* rs_alu.sv */
`timescale 1ns/10ps

module rs_alu import ooo_pkg::*; #(
    parameter int rob_depth = 8,
    parameter int rs_depth = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         accept,
    input  opcode_e                      op,
    input  logic [$clog2(rob_depth)-1:0] tag,
    input  logic [xlen-1:0]              pc,
    input  logic [xlen-1:0]              imm,
    input  logic                         use_imm,
    input  logic [xlen-1:0]              a_value,
    input  logic                         a_pending,
    input  logic [$clog2(rob_depth)-1:0] a_tag,
    input  logic [xlen-1:0]              b_value,
    input  logic                         b_pending,
    input  logic [$clog2(rob_depth)-1:0] b_tag,
    output logic                         full,
    input  logic                         cdb_valid,
    input  logic [$clog2(rob_depth)-1:0] cdb_tag,
    input  logic [xlen-1:0]              cdb_value,
    output logic                         issue_valid,
    output opcode_e                      issue_op,
    output logic [xlen-1:0]              issue_a,
    output logic [xlen-1:0]              issue_b,
    output logic [xlen-1:0]              issue_pc,
    output logic [xlen-1:0]              issue_imm,
    output logic [$clog2(rob_depth)-1:0] issue_tag
);
    localparam int tag_w = $clog2(rob_depth);
    localparam int idx_w = $clog2(rs_depth);

    logic [rs_depth-1:0] busy;
    logic [rs_depth-1:0] a_rdy;
    logic [rs_depth-1:0] b_rdy;
    opcode_e             e_op    [rs_depth];
    logic [tag_w-1:0]    e_tag   [rs_depth];
    logic [xlen-1:0]     e_pc    [rs_depth];
    logic [xlen-1:0]     e_imm   [rs_depth];
    logic [xlen-1:0]     e_a     [rs_depth];
    logic [xlen-1:0]     e_b     [rs_depth];
    logic [tag_w-1:0]    e_a_tag [rs_depth];
    logic [tag_w-1:0]    e_b_tag [rs_depth];
    logic [idx_w-1:0]    e_age   [rs_depth];  // count of younger entries.

    logic [idx_w-1:0] free_idx;
    logic [idx_w-1:0] sel_idx;
    logic             sel_found;
    logic             a_wake;
    logic             b_wake;

    assign full = &busy;
    assign a_wake = cdb_valid && cdb_tag == a_tag;
    assign b_wake = cdb_valid && cdb_tag == b_tag;

    always_comb begin
        free_idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!busy[i]) free_idx = idx_w'(i);
        end
    end

    // oldest entry with both operands present.
    always_comb begin
        sel_found = 1'b0;
        sel_idx = '0;
        for (int i = 0; i < rs_depth; i++) begin
            if (busy[i] && a_rdy[i] && b_rdy[i] &&
                (!sel_found || e_age[i] > e_age[sel_idx])) begin
                sel_found = 1'b1;
                sel_idx = idx_w'(i);
            end
        end
    end

    assign issue_valid = sel_found;
    assign issue_op = e_op[sel_idx];
    assign issue_a = e_a[sel_idx];
    assign issue_b = e_b[sel_idx];
    assign issue_pc = e_pc[sel_idx];
    assign issue_imm = e_imm[sel_idx];
    assign issue_tag = e_tag[sel_idx];

    always_ff @(posedge clk) begin
        if (!rst || flush) begin
            busy <= '0;
        end else begin
            if (sel_found) busy[sel_idx] <= 1'b0;
            if (accept) busy[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (busy[i] && !a_rdy[i] && cdb_valid && cdb_tag == e_a_tag[i]) begin
                e_a[i] <= cdb_value;
                a_rdy[i] <= 1'b1;
            end
            if (busy[i] && !b_rdy[i] && cdb_valid && cdb_tag == e_b_tag[i]) begin
                e_b[i] <= cdb_value;
                b_rdy[i] <= 1'b1;
            end
            if (busy[i] && !(sel_found && sel_idx == idx_w'(i))) begin
                if (accept && !(sel_found && e_age[i] > e_age[sel_idx])) begin
                    e_age[i] <= e_age[i] + 1'b1;
                end else if (!accept && sel_found && e_age[i] > e_age[sel_idx]) begin
                    e_age[i] <= e_age[i] - 1'b1;  // a younger one left.
                end
            end
        end
        if (accept) begin
            e_op[free_idx] <= op;
            e_tag[free_idx] <= tag;
            e_pc[free_idx] <= pc;
            e_imm[free_idx] <= imm;
            e_age[free_idx] <= '0;
            e_a[free_idx] <= a_pending ? cdb_value : a_value;
            a_rdy[free_idx] <= !a_pending || a_wake;
            e_a_tag[free_idx] <= a_tag;
            e_b[free_idx] <= use_imm ? imm : b_pending ? cdb_value : b_value;
            b_rdy[free_idx] <= use_imm || !b_pending || b_wake;
            e_b_tag[free_idx] <= b_tag;
        end
    end

endmodule

/* int_alu.sv */
`timescale 1ns/10ps

module int_alu import ooo_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         issue_valid,
    input  opcode_e                      issue_op,
    input  logic [xlen-1:0]              issue_a,
    input  logic [xlen-1:0]              issue_b,
    input  logic [xlen-1:0]              issue_pc,
    input  logic [xlen-1:0]              issue_imm,
    input  logic [$clog2(rob_depth)-1:0] issue_tag,
    output logic                         cdb_valid,
    output logic [$clog2(rob_depth)-1:0] cdb_tag,
    output logic [xlen-1:0]              cdb_value,
    output logic                         cdb_taken,
    output logic [xlen-1:0]              cdb_target
);
    logic                         s1_valid;
    opcode_e                      s1_op;
    logic [xlen-1:0]              s1_a;
    logic [xlen-1:0]              s1_b;
    logic [xlen-1:0]              s1_pc;
    logic [xlen-1:0]              s1_imm;
    logic [$clog2(rob_depth)-1:0] s1_tag;
    logic [xlen-1:0]              result;
    logic [xlen-1:0]              target;
    logic                         taken;

    assign target = s1_pc + s1_imm;

    always_comb begin
        result = '0;
        taken = 1'b0;
        case (s1_op)
            op_add:  result = s1_a + s1_b;
            op_sub:  result = s1_a - s1_b;
            op_and:  result = s1_a & s1_b;
            op_or:   result = s1_a | s1_b;
            op_xor:  result = s1_a ^ s1_b;
            op_slt:  result = xlen'($signed(s1_a) < $signed(s1_b));
            op_sltu: result = xlen'(s1_a < s1_b);
            op_sll:  result = s1_a << s1_b[4:0];
            op_srl:  result = s1_a >> s1_b[4:0];
            op_sra:  result = $signed(s1_a) >>> s1_b[4:0];
            op_lui:  result = s1_imm;
            op_beq:  taken = s1_a == s1_b;
            op_bne:  taken = s1_a != s1_b;
            op_blt:  taken = $signed(s1_a) < $signed(s1_b);
            op_bge:  taken = $signed(s1_a) >= $signed(s1_b);
            op_jal: begin
                result = s1_pc + xlen'(4);  // link value.
                taken = 1'b1;
            end
            default: result = '0;
        endcase
        if (is_branch(s1_op)) result = target;
    end

    always_ff @(posedge clk) begin
        if (!rst || flush) begin
            s1_valid <= 1'b0;
            cdb_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
            cdb_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op <= issue_op;
        s1_a <= issue_a;
        s1_b <= issue_b;
        s1_pc <= issue_pc;
        s1_imm <= issue_imm;
        s1_tag <= issue_tag;
        cdb_tag <= s1_tag;
        cdb_value <= result;
        cdb_taken <= taken;
        cdb_target <= target;
    end

endmodule

/* rob.sv */
`timescale 1ns/10ps

module rob import ooo_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         alloc_valid,
    input  opcode_e                      alloc_op,
    input  logic [reg_idx_w-1:0]         alloc_rd,
    input  logic [xlen-1:0]              alloc_pc,
    output logic [$clog2(rob_depth)-1:0] alloc_tag,
    output logic                         full,
    input  logic [$clog2(rob_depth)-1:0] query1_tag,
    input  logic [$clog2(rob_depth)-1:0] query2_tag,
    output logic                         query1_ready,
    output logic [xlen-1:0]              query1_value,
    output logic                         query2_ready,
    output logic [xlen-1:0]              query2_value,
    input  logic                         cdb_valid,
    input  logic [$clog2(rob_depth)-1:0] cdb_tag,
    input  logic [xlen-1:0]              cdb_value,
    input  logic                         cdb_taken,
    input  logic [xlen-1:0]              cdb_target,
    output logic                         commit_valid,
    output logic [reg_idx_w-1:0]         commit_rd,
    output logic [xlen-1:0]              commit_value,
    output logic [$clog2(rob_depth)-1:0] commit_tag,
    output logic                         redirect_valid,
    output logic [xlen-1:0]              redirect_pc
);
    localparam int tag_w = $clog2(rob_depth);
    localparam int cnt_w = $clog2(rob_depth + 1);

    typedef enum logic [1:0] {st_empty, st_waiting, st_done} entry_state_e;

    entry_state_e          state    [rob_depth];
    opcode_e               e_op     [rob_depth];
    logic [reg_idx_w-1:0]  e_rd     [rob_depth];
    logic [xlen-1:0]       e_value  [rob_depth];
    logic [xlen-1:0]       e_target [rob_depth];
    logic [rob_depth-1:0]  e_taken;

    logic [tag_w-1:0] head;
    logic [tag_w-1:0] tail;
    logic [cnt_w-1:0] count;
    logic             retire;
    logic             flush_now;
    logic             cdb_hit;

    function automatic logic [tag_w-1:0] next_ptr(input logic [tag_w-1:0] p);
        return (p == tag_w'(rob_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign retire = state[head] == st_done;
    assign flush_now = retire && ((is_branch(e_op[head]) && e_taken[head]) || e_op[head] == op_jal);
    assign cdb_hit = cdb_valid && state[cdb_tag] == st_waiting;  // stale results are dropped.
    assign alloc_tag = tail;
    assign full = count == cnt_w'(rob_depth);

    assign query1_ready = state[query1_tag] == st_done;
    assign query1_value = e_value[query1_tag];
    assign query2_ready = state[query2_tag] == st_done;
    assign query2_value = e_value[query2_tag];

    always_ff @(posedge clk) begin
        if (!rst || flush_now) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            for (int i = 0; i < rob_depth; i++) state[i] <= st_empty;
        end else begin
            if (cdb_hit) state[cdb_tag] <= st_done;
            if (retire) begin
                state[head] <= st_empty;
                head <= next_ptr(head);
            end
            if (alloc_valid) begin
                state[tail] <= st_waiting;
                tail <= next_ptr(tail);
            end
            count <= count + cnt_w'(alloc_valid) - cnt_w'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            commit_valid <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
            redirect_valid <= flush_now;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            e_op[tail] <= alloc_op;
            e_rd[tail] <= alloc_rd;
            e_target[tail] <= alloc_pc + xlen'(4);  // fall-through.
            e_taken[tail] <= 1'b0;
        end
        if (cdb_hit) begin
            e_value[cdb_tag] <= cdb_value;
            e_taken[cdb_tag] <= cdb_taken;
            e_target[cdb_tag] <= cdb_target;
        end
        commit_rd <= is_branch(e_op[head]) ? '0 : e_rd[head];  // branches write nothing.
        commit_value <= e_value[head];
        commit_tag <= head;
        redirect_pc <= e_target[head];
    end

endmodule

/* ooo_core.sv */
`timescale 1ns/10ps

module ooo_core import ooo_pkg::*; #(
    parameter int rob_depth = 8,
    parameter int rs_depth = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         dispatch_valid,
    input  opcode_e                      dispatch_op,
    input  logic [reg_idx_w-1:0]         dispatch_rd,
    input  logic [reg_idx_w-1:0]         dispatch_rs1,
    input  logic [reg_idx_w-1:0]         dispatch_rs2,
    input  logic [xlen-1:0]              dispatch_imm,
    input  logic                         dispatch_use_imm,
    input  logic [xlen-1:0]              dispatch_pc,
    output logic                         dispatch_ready,
    output logic                         commit_valid,
    output logic [reg_idx_w-1:0]         commit_rd,
    output logic [xlen-1:0]              commit_value,
    output logic [$clog2(rob_depth)-1:0] commit_tag,
    output logic                         redirect_valid,
    output logic [xlen-1:0]              redirect_pc
);
    localparam int tag_w = $clog2(rob_depth);

    logic             accept;
    logic             rob_full;
    logic             rs_full;
    logic [tag_w-1:0] alloc_tag;
    logic [xlen-1:0]  rs1_value;
    logic [xlen-1:0]  rs2_value;
    logic             rs1_pending;
    logic             rs2_pending;
    logic [tag_w-1:0] rs1_tag;
    logic [tag_w-1:0] rs2_tag;
    logic             q1_ready;
    logic             q2_ready;
    logic [xlen-1:0]  q1_value;
    logic [xlen-1:0]  q2_value;
    logic             issue_valid;
    opcode_e          issue_op;
    logic [xlen-1:0]  issue_a;
    logic [xlen-1:0]  issue_b;
    logic [xlen-1:0]  issue_pc;
    logic [xlen-1:0]  issue_imm;
    logic [tag_w-1:0] issue_tag;
    logic             cdb_valid;
    logic [tag_w-1:0] cdb_tag;
    logic [xlen-1:0]  cdb_value;
    logic             cdb_taken;
    logic [xlen-1:0]  cdb_target;

    assign dispatch_ready = !rob_full && !rs_full && !redirect_valid;
    assign accept = dispatch_valid && dispatch_ready;

    reg_status #(.rob_depth(rob_depth)) u_reg_status (
        .clk, .rst,
        .rs1(dispatch_rs1), .rs2(dispatch_rs2),
        .rs1_value, .rs2_value, .rs1_pending, .rs2_pending, .rs1_tag, .rs2_tag,
        .alloc_valid(accept), .alloc_rd(dispatch_rd), .alloc_tag,
        .commit_valid, .commit_rd, .commit_value, .commit_tag,
        .flush(redirect_valid)
    );

    // a producer that already finished hands its value over from the rob.
    rs_alu #(.rob_depth(rob_depth), .rs_depth(rs_depth)) u_rs_alu (
        .clk, .rst, .flush(redirect_valid),
        .accept, .op(dispatch_op), .tag(alloc_tag), .pc(dispatch_pc),
        .imm(dispatch_imm), .use_imm(dispatch_use_imm),
        .a_value(rs1_pending ? q1_value : rs1_value),
        .a_pending(rs1_pending && !q1_ready), .a_tag(rs1_tag),
        .b_value(rs2_pending ? q2_value : rs2_value),
        .b_pending(rs2_pending && !q2_ready), .b_tag(rs2_tag),
        .full(rs_full),
        .cdb_valid, .cdb_tag, .cdb_value,
        .issue_valid, .issue_op, .issue_a, .issue_b, .issue_pc, .issue_imm, .issue_tag
    );

    int_alu #(.rob_depth(rob_depth)) u_int_alu (
        .clk, .rst, .flush(redirect_valid),
        .issue_valid, .issue_op, .issue_a, .issue_b, .issue_pc, .issue_imm, .issue_tag,
        .cdb_valid, .cdb_tag, .cdb_value, .cdb_taken, .cdb_target
    );

    rob #(.rob_depth(rob_depth)) u_rob (
        .clk, .rst,
        .alloc_valid(accept), .alloc_op(dispatch_op), .alloc_rd(dispatch_rd),
        .alloc_pc(dispatch_pc), .alloc_tag, .full(rob_full),
        .query1_tag(rs1_tag), .query2_tag(rs2_tag),
        .query1_ready(q1_ready), .query1_value(q1_value),
        .query2_ready(q2_ready), .query2_value(q2_value),
        .cdb_valid, .cdb_tag, .cdb_value, .cdb_taken, .cdb_target,
        .commit_valid, .commit_rd, .commit_value, .commit_tag,
        .redirect_valid, .redirect_pc
    );

endmodule

/* ooo_properties.sv */
`timescale 1ns/10ps

module ooo_properties (
    input logic clk,
    input logic rst,
    input logic alloc_valid,
    input logic full,
    input logic commit_valid,
    input logic redirect_valid
);
    int fails = 0;  // failed assertion count.

    a_redirect_with_commit: assert property (@(posedge clk) disable iff (!rst)
        redirect_valid |-> commit_valid)
        else begin
            fails++;
            $error("redirect raised without a commit");
        end

    // the rob is empty right after a flush.
    a_quiet_after_redirect: assert property (@(posedge clk) disable iff (!rst)
        redirect_valid |=> !commit_valid)
        else begin
            fails++;
            $error("commit in the cycle after a redirect");
        end

    a_no_alloc_when_full: assert property (@(posedge clk) disable iff (!rst)
        !(full && alloc_valid))
        else begin
            fails++;
            $error("allocation while the rob is full");
        end

    a_reset_quiet: assert property (@(posedge clk)
        (!rst && $past(!rst)) |-> !commit_valid)
        else begin
            fails++;
            $error("commit during reset");
        end

endmodule

bind rob ooo_properties u_props (
    .clk, .rst, .alloc_valid, .full, .commit_valid, .redirect_valid
);

/* ooo_checker.sv */
`timescale 1ns/10ps

module ooo_checker import ooo_pkg::*; #(
    parameter int n_tests = 5,
    parameter int rob_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         dispatch_ready,
    input  logic                         commit_valid,
    input  logic [reg_idx_w-1:0]         commit_rd,
    input  logic [xlen-1:0]              commit_value,
    input  logic [$clog2(rob_depth)-1:0] commit_tag,
    input  logic                         redirect_valid,
    input  logic [xlen-1:0]              redirect_pc,
    output int                           tests_done,
    output int                           errors
);
    logic [xlen-1:0]              arch [32];
    logic [xlen-1:0]              pc;
    logic [$clog2(rob_depth)-1:0] exp_tag;
    int                           checks;
    int                           test_commits;
    int                           test_errors;
    logic                         saw_stall;

    task automatic flag(input string what, input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
        $display("mismatch %s at pc %h: got %h expected %h", what, pc, got, exp);
        errors++;
        test_errors++;
    endtask

    task automatic close_test();
        if (tb_ooo_core.t_stall[tests_done] && !saw_stall) begin
            $display("dispatch_ready never fell during test %s", tb_ooo_core.t_name[tests_done]);
            errors++;
            test_errors++;
        end
        $display("test %0d %s: %0d commits, %0d errors", tests_done,
                 tb_ooo_core.t_name[tests_done], test_commits, test_errors);
        tests_done++;
        test_commits = 0;
        test_errors = 0;
        saw_stall = 1'b0;
        if (tests_done < n_tests) begin
            pc = tb_ooo_core.t_start[tests_done];
        end else begin
            $display("closing: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        end
    endtask

    // one architectural step per commit, in program order.
    task automatic check_commit();
        int idx;
        opcode_e op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] res;
        logic [xlen-1:0] nxt;
        logic taken;
        logic [reg_idx_w-1:0] exp_rd;
        idx = int'(pc >> 2);
        op = tb_ooo_core.prog_op[idx];
        imm = tb_ooo_core.prog_imm[idx];
        a = arch[tb_ooo_core.prog_rs1[idx]];
        b = tb_ooo_core.prog_use_imm[idx] ? imm : arch[tb_ooo_core.prog_rs2[idx]];
        res = '0;
        taken = 1'b0;
        case (op)
            op_add:  res = a + b;
            op_sub:  res = a - b;
            op_and:  res = a & b;
            op_or:   res = a | b;
            op_xor:  res = a ^ b;
            op_slt:  res = {31'b0, $signed(a) < $signed(b)};
            op_sltu: res = {31'b0, a < b};
            op_sll:  res = a << b[4:0];
            op_srl:  res = a >> b[4:0];
            op_sra:  res = $signed(a) >>> b[4:0];
            op_lui:  res = imm;
            op_beq:  taken = a == b;
            op_bne:  taken = a != b;
            op_blt:  taken = $signed(a) < $signed(b);
            op_bge:  taken = $signed(a) >= $signed(b);
            op_jal: begin
                res = pc + 32'd4;
                taken = 1'b1;
            end
            default: res = '0;
        endcase
        exp_rd = is_branch(op) ? '0 : tb_ooo_core.prog_rd[idx];
        nxt = taken ? pc + imm : pc + 32'd4;
        checks++;
        if (commit_rd !== exp_rd) flag("commit_rd", xlen'(commit_rd), xlen'(exp_rd));
        if (exp_rd != '0 && commit_value !== res) flag("commit_value", commit_value, res);
        if (commit_tag !== exp_tag) flag("commit_tag", xlen'(commit_tag), xlen'(exp_tag));
        if (redirect_valid !== taken) begin
            flag("redirect_valid", xlen'(redirect_valid), xlen'(taken));
        end else if (taken && redirect_pc !== nxt) begin
            flag("redirect_pc", redirect_pc, nxt);
        end
        if (exp_rd != '0) arch[exp_rd] = res;
        // tags are handed out in a circle and restart at zero after a flush.
        exp_tag = (taken || int'(exp_tag) == rob_depth - 1) ? '0 : exp_tag + 1'b1;
        pc = nxt;
        test_commits++;
        if (test_commits == tb_ooo_core.t_count[tests_done]) close_test();
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) arch[i] = '0;
            pc = tb_ooo_core.t_start[0];
            exp_tag = '0;
            tests_done = 0;
            errors = 0;
            checks = 0;
            test_commits = 0;
            test_errors = 0;
            saw_stall = 1'b0;
        end else if (tests_done < n_tests) begin
            if (!dispatch_ready && !redirect_valid) saw_stall = 1'b1;
            if (commit_valid) begin
                check_commit();
            end else if (redirect_valid) begin
                $display("redirect to %h arrived without a commit", redirect_pc);
                errors++;
                test_errors++;
            end
        end
    end

endmodule

/* tb_ooo_core.sv */
`timescale 1ns/10ps

module tb_ooo_core import ooo_pkg::*; ();
    localparam int n_tests = 5;
    localparam int prog_len = 128;
    localparam int rob_depth = 8;

    opcode_e              prog_op      [prog_len];
    logic [reg_idx_w-1:0] prog_rd      [prog_len];
    logic [reg_idx_w-1:0] prog_rs1     [prog_len];
    logic [reg_idx_w-1:0] prog_rs2     [prog_len];
    logic [xlen-1:0]      prog_imm     [prog_len];
    logic                 prog_use_imm [prog_len];

    // start pc, end pc, commits to retire, name, rob fill expected.
    logic [xlen-1:0] t_start [n_tests] = '{32'd0, 32'd64, 32'd128, 32'd192, 32'd256};
    logic [xlen-1:0] t_end   [n_tests] = '{32'd48, 32'd96, 32'd156, 32'd236, 32'd328};
    int              t_count [n_tests] = '{12, 8, 7, 6, 18};
    string           t_name  [n_tests] = '{"dep_chain", "mixed_order", "branch_not_taken",
                                           "branch_taken", "rob_fill"};
    logic            t_stall [n_tests] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    logic                         clk;
    logic                         rst;
    logic                         dispatch_valid;
    opcode_e                      dispatch_op;
    logic [reg_idx_w-1:0]         dispatch_rd;
    logic [reg_idx_w-1:0]         dispatch_rs1;
    logic [reg_idx_w-1:0]         dispatch_rs2;
    logic [xlen-1:0]              dispatch_imm;
    logic                         dispatch_use_imm;
    logic [xlen-1:0]              dispatch_pc;
    logic                         dispatch_ready;
    logic                         commit_valid;
    logic [reg_idx_w-1:0]         commit_rd;
    logic [xlen-1:0]              commit_value;
    logic [$clog2(rob_depth)-1:0] commit_tag;
    logic                         redirect_valid;
    logic [xlen-1:0]              redirect_pc;
    int                           tests_done;
    int                           errors;

    ooo_core #(.rob_depth(rob_depth), .rs_depth(4)) i_dut (.*);

    ooo_checker #(.n_tests(n_tests), .rob_depth(rob_depth)) u_checker (
        .clk, .rst, .dispatch_ready, .commit_valid, .commit_rd, .commit_value, .commit_tag,
        .redirect_valid, .redirect_pc, .tests_done, .errors
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic put(input int idx, input opcode_e op, input int rd, input int rs1,
                       input int rs2, input logic [xlen-1:0] imm, input logic use_imm);
        prog_op[idx] = op;
        prog_rd[idx] = reg_idx_w'(rd);
        prog_rs1[idx] = reg_idx_w'(rs1);
        prog_rs2[idx] = reg_idx_w'(rs2);
        prog_imm[idx] = imm;
        prog_use_imm[idx] = use_imm;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) put(i, op_add, 0, 0, 0, 0, 1'b0);
        put(0, op_lui, 1, 0, 0, 32'h1234_5678, 1'b1);  // dependent chain.
        put(1, op_add, 2, 1, 0, 32'h10, 1'b1);
        put(2, op_sub, 3, 2, 1, 0, 1'b0);
        put(3, op_xor, 4, 3, 2, 0, 1'b0);
        put(4, op_or, 5, 4, 1, 0, 1'b0);
        put(5, op_and, 6, 5, 2, 0, 1'b0);
        put(6, op_sll, 7, 3, 0, 32'd4, 1'b1);
        put(7, op_srl, 8, 1, 3, 0, 1'b0);
        put(8, op_lui, 9, 0, 0, 32'h8000_0000, 1'b1);
        put(9, op_sra, 10, 9, 3, 0, 1'b0);
        put(10, op_slt, 11, 9, 1, 0, 1'b0);
        put(11, op_sltu, 12, 9, 1, 0, 1'b0);
        put(16, op_lui, 13, 0, 0, 32'd7, 1'b1);  // independents between chains.
        put(17, op_sll, 14, 13, 0, 32'd3, 1'b1);
        put(18, op_lui, 15, 0, 0, 32'habc, 1'b1);
        put(19, op_add, 16, 14, 13, 0, 1'b0);
        put(20, op_add, 17, 15, 0, 32'd1, 1'b1);
        put(21, op_sub, 18, 16, 15, 0, 1'b0);
        put(22, op_xor, 19, 17, 18, 0, 1'b0);
        put(23, op_lui, 20, 0, 0, 32'h55, 1'b1);
        put(32, op_lui, 21, 0, 0, 32'd5, 1'b1);
        put(33, op_lui, 22, 0, 0, 32'd6, 1'b1);
        put(34, op_beq, 0, 21, 22, 32'h20, 1'b0);
        put(35, op_bge, 0, 21, 22, 32'h20, 1'b0);
        put(36, op_add, 23, 21, 22, 0, 1'b0);
        put(37, op_blt, 0, 22, 21, 32'd8, 1'b0);
        put(38, op_or, 24, 23, 0, 0, 1'b0);
        put(48, op_lui, 25, 0, 0, 32'd3, 1'b1);
        put(49, op_bne, 0, 25, 0, 32'd12, 1'b0);
        put(50, op_lui, 26, 0, 0, 32'hdead, 1'b1);  // wrong path.
        put(51, op_lui, 27, 0, 0, 32'hbeef, 1'b1);
        put(52, op_jal, 28, 0, 0, 32'd12, 1'b1);
        put(53, op_add, 25, 25, 0, 32'd100, 1'b1);
        put(54, op_lui, 29, 0, 0, 32'd1, 1'b1);
        put(55, op_add, 29, 28, 25, 0, 1'b0);
        put(56, op_blt, 0, 0, 25, 32'd8, 1'b0);
        put(57, op_lui, 30, 0, 0, 32'd9, 1'b1);
        put(58, op_sub, 30, 29, 25, 0, 1'b0);
        put(64, op_lui, 1, 0, 0, 32'h100, 1'b1);  // slow head, then a burst.
        put(65, op_add, 2, 1, 1, 0, 1'b0);
        put(66, op_sll, 3, 2, 0, 32'd2, 1'b1);
        put(67, op_sub, 4, 3, 1, 0, 1'b0);
        for (int k = 0; k < 12; k++) begin
            put(68 + k, op_add, (k % 4 == 3) ? 0 : 5 + k, 0, 0, xlen'(k * 3 + 1), 1'b1);
        end
        put(80, op_add, 31, 0, 0, 32'd9, 1'b1);
        put(81, op_or, 30, 31, 4, 0, 1'b0);
    endtask

    task automatic drive_slot(input logic [xlen-1:0] at, input logic [xlen-1:0] lo,
                              input logic [xlen-1:0] hi);
        int idx;
        idx = int'(at >> 2);
        dispatch_valid = 1'b0;
        if (at >= lo && at < hi) begin
            dispatch_pc = at;
            dispatch_op = prog_op[idx];
            dispatch_rd = prog_rd[idx];
            dispatch_rs1 = prog_rs1[idx];
            dispatch_rs2 = prog_rs2[idx];
            dispatch_imm = prog_imm[idx];
            dispatch_use_imm = prog_use_imm[idx];
            dispatch_valid = ($urandom % 4) != 0;  // withhold about a quarter.
        end
    endtask

    initial begin
        logic [xlen-1:0] pc;
        logic            took;
        void'($urandom(32'hc9d7));
        rst = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_op = op_add;
        dispatch_rd = '0;
        dispatch_rs1 = '0;
        dispatch_rs2 = '0;
        dispatch_imm = '0;
        dispatch_use_imm = 1'b0;
        dispatch_pc = '0;
        load_program();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        for (int t = 0; t < n_tests; t++) begin
            pc = t_start[t];
            took = 1'b0;
            while (1) begin
                @(negedge clk);
                if (tests_done != t) break;
                if (redirect_valid) pc = redirect_pc;
                else if (took) pc = pc + 32'd4;
                drive_slot(pc, t_start[t], t_end[t]);
                @(posedge clk);
                took = dispatch_valid && dispatch_ready;
            end
            dispatch_valid = 1'b0;
        end
        if (errors == 0 && i_dut.u_rob.u_props.fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog sized by the number of commits the tests expect.
    initial begin
        int budget;
        @(posedge rst);
        budget = 8;
        for (int t = 0; t < n_tests; t++) budget += 40 * t_count[t];
        repeat (budget) @(posedge clk);
        $display("timeout: the core stopped committing before all tests finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* filelist.f */
ooo_pkg.sv
reg_status.sv
rs_alu.sv
int_alu.sv
rob.sv
ooo_core.sv
ooo_properties.sv
ooo_checker.sv
tb_ooo_core.sv
